// ==== bench/scope_tb.sv ====
`timescale 1ns/1ns
////////////////////////////////////////////////////////////////////////////
// scope core testbench
// register access, decimation, averaging, edge trigger, bursts and
// back-pressure against a reference model
////////////////////////////////////////////////////////////////////////////

`include "scope_params.svh"

module scope_tb import scope_pkg::*; ();

  localparam int          TMO   = 2000;  // cycles allowed per wait
  localparam logic [31:0] SEED  = 32'h8029_8c91;
  localparam int          S_MAX = 2 ** (`SCOPE_SAMPLE_W - 1) - 1;
  localparam int          S_MIN = -S_MAX - 1;

  // register map
  localparam logic [5:0] ADR_CTL = 6'h00;
  localparam logic [5:0] ADR_SEL = 6'h08;
  localparam logic [5:0] ADR_DLY = 6'h0C;
  localparam logic [5:0] ADR_LVL = 6'h10;
  localparam logic [5:0] ADR_HST = 6'h14;
  localparam logic [5:0] ADR_AVG = 6'h24;
  localparam logic [5:0] ADR_DEC = 6'h28;
  localparam logic [5:0] ADR_SHR = 6'h2C;
  localparam logic [5:0] MAP_ADR [7] = '{6'h08, 6'h0C, 6'h10, 6'h14, 6'h24, 6'h28, 6'h2C};
  localparam logic [5:0] GAP_ADR [5] = '{6'h04, 6'h18, 6'h1C, 6'h30, 6'h3C};

  logic                        clk;
  logic                        rstn;
  logic                        wb_cyc;
  logic                        wb_stb;
  logic                        wb_we;
  logic [`SCOPE_ADR_W-1:0]     wb_adr;
  logic [31:0]                 wb_dat_w;
  logic [3:0]                  wb_sel;
  logic [31:0]                 wb_dat_r;
  logic                        wb_ack;
  sample_t                     sti_dat;
  logic                        sti_vld;
  logic                        sti_rdy;
  sample_t                     sto_dat;
  logic                        sto_vld;
  logic                        sto_lst;
  logic                        sto_rdy;
  logic [`SCOPE_TRG_EXT_W-1:0] trg_ext;
  logic [1:0]                  trg_out;

  // error and event counters
  int n_checks;
  int n_mismatch;
  int n_other;
  int n_out;    // sto transfers
  int n_pdg;    // rising pulses seen
  int n_ndg;
  int n_stall;  // cycles with both stages full

  // reference model state
  sample_t exp_q[$];  // expected output samples
  logic    lst_q[$];  // expected last flags
  bit      m_avg;
  int      m_dec;
  int      m_shr;
  int      m_lvl;
  int      m_hst;
  int      m_grp;     // inputs taken in group
  longint  m_sum;
  bit      m_acq;
  bit      m_trg;
  int      m_cnt;     // samples left after trigger
  bit      m_st;      // schmitt state
  int      exp_pdg;
  int      exp_ndg;

  logic [31:0] seed;
  logic [31:0] rdy_seed;  // own stream for sto_rdy
  bit          rdy_rand;
  sample_t     exp_s;
  logic        exp_l;

  scope_top dut_i (
    .clk, .rstn,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel, .wb_dat_r, .wb_ack,
    .sti_dat, .sti_vld, .sti_rdy,
    .sto_dat, .sto_vld, .sto_lst, .sto_rdy,
    .trg_ext, .trg_out
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // random numbers and reference model

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rand32();
    seed = lcg(seed);
    return seed;
  endfunction

  // mostly uniform, with full-scale values mixed in
  function automatic sample_t rand_sample();
    logic [31:0] r;
    r = rand32();
    case (r[30:28])
      3'd0:    return sample_t'(S_MAX);
      3'd1:    return sample_t'(S_MIN);
      default: return sample_t'(r[31:18]);
    endcase
  endfunction

  // one decimated output from a completed group
  function automatic sample_t group_out(input longint sum, input sample_t last_s,
                                        input bit avg, input int shr);
    longint v;
    if (!avg)
      return last_s;
    v = sum >>> shr;
    if (v > S_MAX)
      return sample_t'(S_MAX);
    if (v < S_MIN)
      return sample_t'(S_MIN);
    return sample_t'(v);
  endfunction

  // readback view of a written word
  function automatic logic [31:0] reg_view(input logic [5:0] adr, input logic [31:0] v);
    case (adr)
      ADR_SEL:          return {29'd0, v[2:0]};
      ADR_DLY:          return {16'd0, v[15:0]};
      ADR_LVL, ADR_HST: return {{(32 - `SCOPE_SAMPLE_W){v[`SCOPE_SAMPLE_W-1]}},
                                v[`SCOPE_SAMPLE_W-1:0]};
      ADR_AVG:          return {31'd0, v[0]};
      ADR_DEC:          return {24'd0, v[7:0]};
      ADR_SHR:          return {28'd0, v[3:0]};
      default:          return 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] lane_mix(input logic [31:0] old_v, input logic [31:0] new_v,
                                           input logic [3:0] sel);
    logic [31:0] mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (new_v & mask) | (old_v & ~mask);
  endfunction

  // decimated sample reaching the acquisition stage
  task automatic model_out(input sample_t y);
    logic lst;
    if (m_acq) begin
      lst = m_trg && (m_cnt == 0);
      exp_q.push_back(y);
      lst_q.push_back(lst);
      if (lst) begin
        m_acq = 1'b0;  // burst over
        m_trg = 1'b0;
      end else if (m_trg) begin
        m_cnt--;
      end
    end
  endtask

  // every accepted input sample
  task automatic model_in(input sample_t d);
    int      d_n;
    sample_t y;
    d_n   = (m_dec == 0) ? 1 : m_dec;
    m_sum = (m_grp == 0) ? longint'(d) : m_sum + d;
    m_grp++;
    if (m_grp >= d_n) begin
      m_grp = 0;
      y     = group_out(m_sum, d, m_avg, m_shr);
      model_out(y);
    end
    // schmitt edges
    if (!m_st && int'(d) >= m_lvl + m_hst) begin
      m_st = 1'b1;
      exp_pdg++;
    end else if (m_st && int'(d) <= m_lvl - m_hst) begin
      m_st = 1'b0;
      exp_ndg++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks

  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    n_checks++;
    if (got !== exp) begin
      n_mismatch++;
      $display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_mismatch++;
      $display("MISMATCH at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_mismatch++;
      $display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // bus and stream drivers, entered and left on a falling edge

  task automatic bus_cycle(input logic we, input logic [5:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel, output logic [31:0] rd);
    int   n;
    logic acked;
    n        = 0;
    rd       = '0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    wb_sel   = sel;
    @(posedge clk);
    while (!wb_ack && n < TMO) begin
      n++;
      @(posedge clk);
    end
    acked = wb_ack;
    if (acked) begin
      rd = wb_dat_r;  // valid with ack
    end else begin
      n_other++;
      $display("timeout at %0t ns: no wishbone ack for address 0x%h", $time, adr);
    end
    @(negedge clk);
    if (acked)
      check_bit("wb_ack", wb_ack, 1'b0);  // request still held, ack must drop
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [5:0] adr, input logic [31:0] dat, input logic [3:0] sel);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, dat, sel, unused);
  endtask

  task automatic wb_read(input logic [5:0] adr, output logic [31:0] rd);
    bus_cycle(1'b0, adr, 32'd0, 4'hF, rd);
  endtask

  task automatic send_sample(input sample_t d);
    int n;
    n       = 0;
    sti_dat = d;
    sti_vld = 1'b1;
    @(posedge clk);
    while (!sti_rdy && n < TMO) begin
      n++;
      @(posedge clk);
    end
    if (sti_rdy) begin
      model_in(d);
    end else begin
      n_other++;
      $display("timeout at %0t ns: input sample %0d never accepted", $time, d);
    end
    @(negedge clk);
    sti_vld = 1'b0;
  endtask

  // wait until every expected sample is out
  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < TMO) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      n_other++;
      $display("timeout at %0t ns: %0d expected output samples never came out",
               $time, exp_q.size());
      exp_q.delete();
      lst_q.delete();
    end
    repeat (4) @(negedge clk);  // edge pulses and stray outputs settle
  endtask

  task automatic configure(input bit avg, input int dec, input int shr, input int lvl,
                           input int hst, input int sel, input int dly);
    wb_write(ADR_AVG, 32'(avg), 4'hF);
    wb_write(ADR_DEC, 32'(dec), 4'hF);
    wb_write(ADR_SHR, 32'(shr), 4'hF);
    wb_write(ADR_LVL, 32'(lvl), 4'hF);
    wb_write(ADR_HST, 32'(hst), 4'hF);
    wb_write(ADR_SEL, 32'(sel), 4'hF);
    wb_write(ADR_DLY, 32'(dly), 4'hF);
    m_avg = avg;
    m_dec = dec;
    m_shr = shr;
    m_lvl = lvl;
    m_hst = hst;
  endtask

  task automatic clear_run();
    wb_write(ADR_CTL, 32'h1, 4'hF);
    m_acq = 1'b0;
    m_trg = 1'b0;
    m_grp = 0;  // partial group dropped
  endtask

  task automatic arm_run();
    wb_write(ADR_CTL, 32'h4, 4'hF);
    m_acq = 1'b1;
    m_trg = 1'b0;
  endtask

  task automatic model_trigger(input int dly);
    if (m_acq && !m_trg) begin
      m_trg = 1'b1;
      m_cnt = dly;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // output monitor

  always @(negedge clk) begin
    rdy_seed = lcg(rdy_seed);
    sto_rdy  = rdy_rand ? (rdy_seed[23:22] == 2'b00) : 1'b1;  // mostly stalled
  end

  always @(posedge clk) begin
    if (rstn) begin
      if (trg_out[0])
        n_pdg++;
      if (trg_out[1])
        n_ndg++;
      // decimator and output register both full
      if (dut_i.st_dec.vld && sto_vld && !sto_rdy) begin
        n_stall++;
        check_bit("sti_rdy", sti_rdy, 1'b0);
      end
      if (sto_vld && sto_rdy) begin
        n_out++;
        if (exp_q.size() == 0) begin
          n_other++;
          $display("error at %0t ns: output sample %0d came out with none expected",
                   $time, sto_dat);
        end else begin
          exp_s = exp_q.pop_front();
          exp_l = lst_q.pop_front();
          check_sample("sto_dat", sto_dat, exp_s);
          check_bit("sto_lst", sto_lst, exp_l);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence

  initial begin
    logic [31:0] rd;
    logic [31:0] wr;
    logic [31:0] wr2;
    logic [31:0] r;
    int          base;
    int          k;
    rstn     = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    wb_sel   = '0;
    sti_dat  = '0;
    sti_vld  = 1'b0;
    sto_rdy  = 1'b1;
    trg_ext  = '0;
    seed     = SEED;
    rdy_seed = lcg(SEED);
    rdy_rand = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;

    // register readback, full and partial writes
    for (int i = 0; i < 7; i++) begin
      wr = rand32();
      wb_write(MAP_ADR[i], wr, 4'hF);
      wb_read(MAP_ADR[i], rd);
      check_word($sformatf("reg 0x%h", MAP_ADR[i]), rd, reg_view(MAP_ADR[i], wr));
      wr2 = rand32();
      r   = rand32();
      wb_write(MAP_ADR[i], wr2, r[27:24]);
      wb_read(MAP_ADR[i], rd);
      check_word($sformatf("reg 0x%h lanes %b", MAP_ADR[i], r[27:24]), rd,
                 reg_view(MAP_ADR[i], lane_mix(reg_view(MAP_ADR[i], wr), wr2, r[27:24])));
    end
    for (int i = 0; i < 5; i++) begin
      wb_write(GAP_ADR[i], rand32(), 4'hF);
      wb_read(GAP_ADR[i], rd);
      check_word($sformatf("unmapped 0x%h", GAP_ADR[i]), rd, 32'd0);
    end
    wb_read(ADR_CTL, rd);
    check_word("status after reset", rd, 32'd0);

    // plain decimation by 3, never triggered
    configure(1'b0, 3, 0, 0, 100, 7, 0);
    clear_run();
    arm_run();
    base = n_out;
    for (int i = 0; i < 30; i++)
      send_sample(sample_t'(i * 97 - 1400));
    wait_drain();
    check_word("decimated count", 32'(n_out - base), 32'd10);

    // averaging of 4, shifted by 2 and then unshifted to saturate
    configure(1'b1, 4, 2, 0, 100, 7, 0);
    clear_run();
    arm_run();
    for (int i = 0; i < 40; i++)
      send_sample(rand_sample());
    wait_drain();
    wb_write(ADR_SHR, 32'd0, 4'hF);
    m_shr = 0;
    for (int i = 0; i < 40; i++)
      send_sample(rand_sample());
    wait_drain();

    // edge pulses, including thresholds beyond full scale
    for (int j = 0; j < 3; j++) begin
      configure(1'b0, 1, 0, (j == 0) ? 200 : (j == 1) ? 8000 : -8000,
                (j == 0) ? 1000 : 500, 7, 0);
      clear_run();
      for (int i = 0; i < 80; i++)
        send_sample(rand_sample());
      wait_drain();
      check_word("trg_out[0] pulses", 32'(n_pdg), 32'(exp_pdg));
      check_word("trg_out[1] pulses", 32'(n_ndg), 32'(exp_ndg));
    end

    // external trigger with 5 samples after it
    r = rand32();
    k = int'(r[25:24]);
    configure(1'b0, 1, 0, 0, 100, 3 + k, 5);
    clear_run();
    arm_run();
    wb_read(ADR_CTL, rd);
    check_word("status armed", rd, 32'h4);
    for (int i = 0; i < 3; i++)
      send_sample(rand_sample());  // pre-trigger
    wait_drain();
    trg_ext[k] = 1'b1;
    @(negedge clk);
    trg_ext = '0;
    model_trigger(5);
    wb_read(ADR_CTL, rd);
    check_word("status triggered", rd, 32'h6);
    base = n_out;
    for (int i = 0; i < 10; i++)
      send_sample(rand_sample());
    wait_drain();
    check_word("burst count", 32'(n_out - base), 32'd6);
    wb_read(ADR_CTL, rd);
    check_word("status after burst", rd, 32'd0);

    // software trigger, then a clear cuts the burst short
    wb_write(ADR_SEL, 32'd0, 4'hF);
    wb_write(ADR_DLY, 32'd20, 4'hF);
    clear_run();
    arm_run();
    wb_write(ADR_CTL, 32'h2, 4'hF);
    model_trigger(20);
    base = n_out;
    for (int i = 0; i < 4; i++)
      send_sample(rand_sample());
    wait_drain();
    clear_run();
    for (int i = 0; i < 5; i++)
      send_sample(rand_sample());
    wait_drain();
    check_word("count around clear", 32'(n_out - base), 32'd4);
    wb_read(ADR_CTL, rd);
    check_word("status after clear", rd, 32'd0);

    // random back-pressure on the output
    configure(1'b1, 2, 1, 0, 100, 7, 0);
    clear_run();
    arm_run();
    base     = n_stall;
    rdy_rand = 1'b1;
    for (int i = 0; i < 60; i++)
      send_sample(rand_sample());
    wait_drain();
    rdy_rand = 1'b0;
    if (n_stall == base) begin
      n_other++;
      $display("error: output back-pressure never filled both pipeline stages");
    end

    $display("checks %0d, mismatches %0d, other errors %0d", n_checks, n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the scope core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module scope_tb -f tb.f -o Vscope_tb

# transcript kept for the verdict
obj_dir/Vscope_tb > sim.log 2>&1
cat sim.log

if grep -q "Test FAILED" sim.log; then
  exit 1
fi
exit 0

// ==== tb.f ====
+incdir+verilog
verilog/scope_pkg.sv
verilog/scope_stream_if.sv
verilog/scope_regs.sv
verilog/scope_dec_avg.sv
verilog/scope_edge.sv
verilog/scope_acq.sv
verilog/scope_top.sv
bench/scope_tb.sv

// ==== verilog/scope_acq.sv ====
`timescale 1ns/1ns
////////////////////////////////////////////////////////////////////////////
// acquisition control
// arm, trigger select, post-trigger count and gated output register
////////////////////////////////////////////////////////////////////////////

`include "scope_params.svh"

module scope_acq import scope_pkg::*; (
  input  logic                        clk,
  input  logic                        rstn,
  input  scope_cfg_t                  cfg,
  // control pulses
  input  logic                        ctl_clr,
  input  logic                        ctl_trg,  // software trigger
  input  logic                        ctl_arm,
  // trigger sources
  input  logic                        trg_pdg,
  input  logic                        trg_ndg,
  input  logic [`SCOPE_TRG_EXT_W-1:0] trg_ext,  // sampled as is
  // decimated stream
  scope_stream_if.sink                sti,
  // output stream
  output sample_t                     sto_dat,
  output logic                        sto_vld,
  output logic                        sto_lst,
  input  logic                        sto_rdy,
  // status
  output logic                        sts_acq,
  output logic                        sts_trg
);

  logic                    trg_mux;  // selected source
  logic                    fire;
  logic                    take;     // sample goes to the output
  logic                    last;     // final sample of the run
  logic [`SCOPE_DLY_W-1:0] cnt_q;    // samples left after trigger

  always_comb begin
    case (cfg.sel)
      TRG_SW:   trg_mux = ctl_trg;
      TRG_PDG:  trg_mux = trg_pdg;
      TRG_NDG:  trg_mux = trg_ndg;
      TRG_EXT0: trg_mux = trg_ext[0];
      TRG_EXT1: trg_mux = trg_ext[1];
      TRG_EXT2: trg_mux = trg_ext[2];
      TRG_EXT3: trg_mux = trg_ext[3];
      default:  trg_mux = 1'b0;  // code 7
    endcase
  end

  assign sti.rdy = ~sto_vld | sto_rdy;  // stall decimator on back-pressure
  assign take    = sti.vld & sti.rdy & sts_acq;  // not acquiring, dropped
  assign fire    = sts_acq & ~sts_trg & trg_mux;
  assign last    = take & sts_trg & (cnt_q == '0);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sts_acq <= 1'b0;
      sts_trg <= 1'b0;
      cnt_q   <= '0;
      sto_vld <= 1'b0;
      sto_lst <= 1'b0;
    end else if (ctl_clr) begin
      sts_acq <= 1'b0;
      sts_trg <= 1'b0;
      sto_vld <= 1'b0;
      sto_lst <= 1'b0;
    end else begin
      if (ctl_arm) begin
        sts_acq <= 1'b1;
        sts_trg <= 1'b0;
      end else if (fire) begin
        sts_trg <= 1'b1;
        cnt_q   <= cfg.dly;
      end else if (last) begin
        sts_acq <= 1'b0;  // run done
        sts_trg <= 1'b0;
      end else if (take && sts_trg) begin
        cnt_q <= cnt_q - 1'b1;
      end
      // output register
      if (sto_rdy) begin
        sto_vld <= 1'b0;
        sto_lst <= 1'b0;
      end
      if (take) begin
        sto_vld <= 1'b1;
        sto_lst <= last;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take)
      sto_dat <= sti.dat;
  end

  a_lst_vld: assert property (@(posedge clk) disable iff (!rstn) sto_lst |-> sto_vld);

endmodule

// ==== verilog/scope_dec_avg.sv ====
`timescale 1ns/1ns
////////////////////////////////////////////////////////////////////////////
// decimator with optional block averaging
// group sum is shifted right and saturated to the sample range
////////////////////////////////////////////////////////////////////////////

`include "scope_params.svh"

module scope_dec_avg import scope_pkg::*; (
  input  logic           clk,
  input  logic           rstn,
  input  logic           ctl_clr,  // drop partial group and output
  input  scope_cfg_t     cfg,
  // input stream
  input  sample_t        sti_dat,
  input  logic           sti_vld,
  output logic           sti_rdy,
  // decimated stream
  scope_stream_if.source sto
);

  localparam int ACC_W = `SCOPE_SAMPLE_W + `SCOPE_DEC_W;  // 255 full-scale samples fit
  localparam logic signed [ACC_W-1:0] SAT_MAX = ACC_W'(2 ** (`SCOPE_SAMPLE_W - 1) - 1);
  localparam logic signed [ACC_W-1:0] SAT_MIN = ~SAT_MAX;

  logic [`SCOPE_DEC_W-1:0] dec_n;     // group size
  logic [`SCOPE_DEC_W-1:0] cnt_q;     // samples taken in group
  logic                    grp_end;   // this input completes the group
  logic                    sti_xfer;
  logic signed [ACC_W-1:0] acc_q;     // running sum
  logic signed [ACC_W-1:0] acc_nxt;
  logic signed [ACC_W-1:0] acc_shr;
  sample_t                 avg_sat;   // scaled, clipped average

  assign dec_n    = (cfg.dec == '0) ? `SCOPE_DEC_W'(1) : cfg.dec;
  assign grp_end  = (cnt_q >= dec_n - 1'b1);  // >= copes with dec lowered mid-group
  assign sti_rdy  = ~sto.vld | sto.rdy;
  assign sti_xfer = sti_vld & sti_rdy;

  // first sample of a group restarts the sum
  assign acc_nxt = (cnt_q == '0) ? ACC_W'(sti_dat) : acc_q + ACC_W'(sti_dat);
  assign acc_shr = acc_nxt >>> cfg.shr;

  always_comb begin
    if (acc_shr > SAT_MAX)
      avg_sat = sample_t'(SAT_MAX);
    else if (acc_shr < SAT_MIN)
      avg_sat = sample_t'(SAT_MIN);
    else
      avg_sat = sample_t'(acc_shr);
  end

  // group counter and output valid
  always_ff @(posedge clk) begin
    if (!rstn) begin
      cnt_q   <= '0;
      sto.vld <= 1'b0;
    end else if (ctl_clr) begin
      cnt_q   <= '0;
      sto.vld <= 1'b0;
    end else begin
      if (sto.rdy)
        sto.vld <= 1'b0;  // taken
      if (sti_xfer) begin
        cnt_q <= grp_end ? '0 : cnt_q + 1'b1;
        if (grp_end)
          sto.vld <= 1'b1;
      end
    end
  end

  // sum and output sample
  always_ff @(posedge clk) begin
    if (sti_xfer)
      acc_q <= acc_nxt;
    if (sti_xfer && grp_end)
      sto.dat <= cfg.avg ? avg_sat : sti_dat;  // plain mode keeps last of group
  end

  assign sto.lst = 1'b0;  // bursts are framed downstream

  a_dat_hold: assert property (@(posedge clk) disable iff (!rstn)
    sto.vld && !sto.rdy |=> $stable(sto.dat));

endmodule

// ==== verilog/scope_edge.sv ====
`timescale 1ns/1ns
////////////////////////////////////////////////////////////////////////////
// schmitt-trigger edge detector
// rising and falling pulses from the accepted input samples
////////////////////////////////////////////////////////////////////////////

`include "scope_params.svh"

module scope_edge import scope_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  input  scope_cfg_t cfg,
  // monitored input stream
  input  sample_t    sti_dat,
  input  logic       sti_vld,
  input  logic       sti_rdy,
  // trigger pulses
  output logic       trg_pdg,
  output logic       trg_ndg
);

  localparam int TW = `SCOPE_SAMPLE_W + 1;  // one guard bit

  logic signed [TW-1:0] thr_hi;   // lvl + hst
  logic signed [TW-1:0] thr_lo;   // lvl - hst
  logic signed [TW-1:0] dat_x;
  logic                 sti_xfer;
  logic                 st_q;     // 1 above the band

  assign thr_hi   = TW'(cfg.lvl) + TW'(cfg.hst);
  assign thr_lo   = TW'(cfg.lvl) - TW'(cfg.hst);
  assign dat_x    = TW'(sti_dat);
  assign sti_xfer = sti_vld & sti_rdy;  // only real transfers count

  always_ff @(posedge clk) begin
    if (!rstn) begin
      st_q    <= 1'b0;
      trg_pdg <= 1'b0;
      trg_ndg <= 1'b0;
    end else begin
      trg_pdg <= 1'b0;
      trg_ndg <= 1'b0;
      if (sti_xfer) begin
        if (!st_q && dat_x >= thr_hi) begin
          st_q    <= 1'b1;
          trg_pdg <= 1'b1;
        end else if (st_q && dat_x <= thr_lo) begin
          st_q    <= 1'b0;
          trg_ndg <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== verilog/scope_params.svh ====
////////////////////////////////////////////////////////////////////////////
// scope core widths
// sample, decimation, shift, delay and bus address sizes
////////////////////////////////////////////////////////////////////////////

`ifndef SCOPE_PARAMS_SVH
`define SCOPE_PARAMS_SVH

// sample stream
`define SCOPE_SAMPLE_W 14  // signed adc sample

// decimation and averaging
`define SCOPE_DEC_W 8  // decimation factor
`define SCOPE_SHR_W 4  // averaging shift right

// trigger
`define SCOPE_DLY_W 16  // post-trigger sample count
`define SCOPE_TRG_EXT_W 4  // external trigger lines

// register bus
`define SCOPE_ADR_W 6  // byte address

`endif

// ==== verilog/scope_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// scope core shared types
// sample type, trigger source encoding and the configuration record
////////////////////////////////////////////////////////////////////////////

`include "scope_params.svh"

package scope_pkg;

  typedef logic signed [`SCOPE_SAMPLE_W-1:0] sample_t;  // one adc sample

  // trigger sources, code 7 never fires
  typedef enum logic [2:0] {
    TRG_SW   = 3'd0,  // software pulse
    TRG_PDG  = 3'd1,  // rising edge of input
    TRG_NDG  = 3'd2,  // falling edge of input
    TRG_EXT0 = 3'd3,
    TRG_EXT1 = 3'd4,
    TRG_EXT2 = 3'd5,
    TRG_EXT3 = 3'd6
  } trg_src_e;

  typedef struct packed {
    logic                    avg;  // averaging enable
    logic [`SCOPE_DEC_W-1:0] dec;  // decimation factor, 0 acts as 1
    logic [`SCOPE_SHR_W-1:0] shr;  // shift of the group sum
    sample_t                 lvl;  // edge level
    sample_t                 hst;  // edge hysteresis
    trg_src_e                sel;  // trigger select
    logic [`SCOPE_DLY_W-1:0] dly;  // samples after trigger
  } scope_cfg_t;

endpackage

// ==== verilog/scope_regs.sv ====
`timescale 1ns/1ns
////////////////////////////////////////////////////////////////////////////
// scope register block
// wishbone classic slave, configuration, control pulses, status readback
////////////////////////////////////////////////////////////////////////////

`include "scope_params.svh"

module scope_regs import scope_pkg::*; (
  input  logic                    clk,
  input  logic                    rstn,
  // wishbone classic slave
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic [`SCOPE_ADR_W-1:0] wb_adr,
  input  logic [31:0]             wb_dat_w,
  input  logic [3:0]              wb_sel,
  output logic [31:0]             wb_dat_r,
  output logic                    wb_ack,
  // status
  input  logic                    sts_acq,
  input  logic                    sts_trg,
  // configuration and control
  output scope_cfg_t              cfg,
  output logic                    ctl_clr,
  output logic                    ctl_trg,
  output logic                    ctl_arm
);

  localparam logic [`SCOPE_ADR_W-1:0] ADR_CTL = 6'h00;
  localparam logic [`SCOPE_ADR_W-1:0] ADR_SEL = 6'h08;
  localparam logic [`SCOPE_ADR_W-1:0] ADR_DLY = 6'h0C;
  localparam logic [`SCOPE_ADR_W-1:0] ADR_LVL = 6'h10;
  localparam logic [`SCOPE_ADR_W-1:0] ADR_HST = 6'h14;
  localparam logic [`SCOPE_ADR_W-1:0] ADR_AVG = 6'h24;
  localparam logic [`SCOPE_ADR_W-1:0] ADR_DEC = 6'h28;
  localparam logic [`SCOPE_ADR_W-1:0] ADR_SHR = 6'h2C;

  logic        wb_req;  // new request, not yet acked
  logic        wb_wr;   // write request
  logic        ctl_wr;  // write to control, lane 0
  logic [31:0] rd_mux;  // current register value
  logic [31:0] wr_val;  // register value after lane merge

  // replace the byte lanes picked by sel
  function automatic logic [31:0] lane_merge(
    input logic [31:0] cur,
    input logic [31:0] dat,
    input logic [3:0]  sel
  );
    logic [31:0] res;
    res = cur;
    for (int i = 0; i < 4; i++) begin
      if (sel[i])
        res[8*i +: 8] = dat[8*i +: 8];
    end
    return res;
  endfunction

  assign wb_req = wb_cyc & wb_stb & ~wb_ack;
  assign wb_wr  = wb_req & wb_we;
  assign ctl_wr = wb_wr & (wb_adr == ADR_CTL) & wb_sel[0];

  always_comb begin
    case (wb_adr)
      ADR_CTL: rd_mux = {29'd0, sts_acq, sts_trg, 1'b0};
      ADR_SEL: rd_mux = {29'd0, cfg.sel};
      ADR_DLY: rd_mux = 32'(cfg.dly);
      ADR_LVL: rd_mux = 32'(cfg.lvl);  // signed, so sign-extended
      ADR_HST: rd_mux = 32'(cfg.hst);
      ADR_AVG: rd_mux = {31'd0, cfg.avg};
      ADR_DEC: rd_mux = 32'(cfg.dec);
      ADR_SHR: rd_mux = 32'(cfg.shr);
      default: rd_mux = '0;  // unmapped
    endcase
  end

  assign wr_val = lane_merge(rd_mux, wb_dat_w, wb_sel);

  ////////////////////////////////////////////////////////////////////////////
  // handshake and control pulses

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wb_ack  <= 1'b0;
      ctl_clr <= 1'b0;
      ctl_trg <= 1'b0;
      ctl_arm <= 1'b0;
    end else begin
      wb_ack  <= wb_req;  // one cycle, every access is 2 clocks
      ctl_clr <= ctl_wr & wb_dat_w[0];
      ctl_trg <= ctl_wr & wb_dat_w[1];
      ctl_arm <= ctl_wr & wb_dat_w[2];
    end
  end

  always_ff @(posedge clk) begin
    if (wb_req)
      wb_dat_r <= rd_mux;  // valid during ack
  end

  ////////////////////////////////////////////////////////////////////////////
  // configuration

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cfg <= '0;
    end else if (wb_wr) begin
      case (wb_adr)
        ADR_SEL: cfg.sel <= trg_src_e'(wr_val[2:0]);
        ADR_DLY: cfg.dly <= wr_val[`SCOPE_DLY_W-1:0];
        ADR_LVL: cfg.lvl <= wr_val[`SCOPE_SAMPLE_W-1:0];
        ADR_HST: cfg.hst <= wr_val[`SCOPE_SAMPLE_W-1:0];
        ADR_AVG: cfg.avg <= wr_val[0];
        ADR_DEC: cfg.dec <= wr_val[`SCOPE_DEC_W-1:0];
        ADR_SHR: cfg.shr <= wr_val[`SCOPE_SHR_W-1:0];
        default: ;  // control and unmapped hold no state
      endcase
    end
  end

  // master keeps stb up until ack, so a held request must not re-ack
  a_ack_single: assert property (@(posedge clk) disable iff (!rstn)
    wb_ack |=> !wb_ack);

endmodule

// ==== verilog/scope_stream_if.sv ====
`timescale 1ns/1ns
////////////////////////////////////////////////////////////////////////////
// sample stream interface
// valid/ready handshake with a last marker for burst ends
////////////////////////////////////////////////////////////////////////////

interface scope_stream_if import scope_pkg::*; ();

  sample_t dat;  // payload
  logic    vld;  // source has a sample
  logic    rdy;  // sink takes it this clock
  logic    lst;  // last sample of a burst

  // producer side, holds dat/vld/lst until taken
  modport source (
    output dat,
    output vld,
    output lst,
    input  rdy
  );

  // consumer side
  modport sink (
    input  dat,
    input  vld,
    input  lst,
    output rdy
  );

endinterface

// ==== verilog/scope_top.sv ====
`timescale 1ns/1ns
////////////////////////////////////////////////////////////////////////////
// oscilloscope acquisition core
// registers, decimator, edge trigger and acquisition control
////////////////////////////////////////////////////////////////////////////

`include "scope_params.svh"

module scope_top import scope_pkg::*; (
  input  logic                        clk,
  input  logic                        rstn,
  // wishbone classic slave
  input  logic                        wb_cyc,
  input  logic                        wb_stb,
  input  logic                        wb_we,
  input  logic [`SCOPE_ADR_W-1:0]     wb_adr,
  input  logic [31:0]                 wb_dat_w,
  input  logic [3:0]                  wb_sel,
  output logic [31:0]                 wb_dat_r,
  output logic                        wb_ack,
  // input stream
  input  sample_t                     sti_dat,
  input  logic                        sti_vld,
  output logic                        sti_rdy,
  // output stream
  output sample_t                     sto_dat,
  output logic                        sto_vld,
  output logic                        sto_lst,
  input  logic                        sto_rdy,
  // triggers
  input  logic [`SCOPE_TRG_EXT_W-1:0] trg_ext,
  output logic [1:0]                  trg_out  // {falling, rising}
);

  scope_cfg_t cfg;
  logic       ctl_clr, ctl_trg, ctl_arm;
  logic       sts_acq, sts_trg;

  scope_stream_if st_dec ();  // decimator to acquisition

  scope_regs regs_i (
    .clk, .rstn,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel, .wb_dat_r, .wb_ack,
    .sts_acq, .sts_trg,
    .cfg, .ctl_clr, .ctl_trg, .ctl_arm
  );

  scope_dec_avg dec_i (
    .clk, .rstn, .ctl_clr, .cfg,
    .sti_dat, .sti_vld, .sti_rdy,
    .sto (st_dec.source)
  );

  // watches the raw input, never stalls it
  scope_edge edge_i (
    .clk, .rstn, .cfg,
    .sti_dat, .sti_vld, .sti_rdy,
    .trg_pdg (trg_out[0]),
    .trg_ndg (trg_out[1])
  );

  scope_acq acq_i (
    .clk, .rstn, .cfg,
    .ctl_clr, .ctl_trg, .ctl_arm,
    .trg_pdg (trg_out[0]),
    .trg_ndg (trg_out[1]),
    .trg_ext,
    .sti (st_dec.sink),
    .sto_dat, .sto_vld, .sto_lst, .sto_rdy,
    .sts_acq, .sts_trg
  );

endmodule
